// ==== filelist.f ====
hw/rvIsaPkg.sv
hw/decodeCtrlPkg.sv
hw/intDecoder.sv
hw/fpDecoder.sv
hw/decodeExecReg.sv
hw/decoderTop.sv
test/decoderTop_properties.sv
test/tb_decoderTop.sv

// ==== test/tb_decoderTop.sv ====
`timescale 1ns/1ps

module tb_decoderTop;

    localparam int ClkPeriod  = 10;
    localparam int ResetCycles = 16;
    localparam int TotalItems = 220; // sum of the item counts below

    typedef struct packed {
        rvIsaPkg::instrWord     instr;
        decodeCtrlPkg::ctrlWord ctrl;
    } expItemT;

    logic                   clk = 1'b0;
    logic                   arstN;
    logic                   inValid;
    logic                   inReady;
    rvIsaPkg::instrWord     inInstr;
    logic                   outValid;
    logic                   outReady;
    rvIsaPkg::instrWord     outInstr;
    decodeCtrlPkg::ctrlWord outCtrl;

    integer  seed;
    int      errorCount = 0;
    int      checkCount = 0;
    int      testCount  = 0;
    expItemT expQ[$];

    decoderTop decoderTop_inst (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inInstr  (inInstr),
        .outValid (outValid),
        .outReady (outReady),
        .outInstr (outInstr),
        .outCtrl  (outCtrl)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic decodeCtrlPkg::aluOpT intAluOp(input logic isReg,
                                                      input rvIsaPkg::funct3T f3,
                                                      input rvIsaPkg::funct7T f7);
        decodeCtrlPkg::aluOpT op;
        case (f3)
            3'd0: op = (!isReg || f7 == rvIsaPkg::F7Base) ? decodeCtrlPkg::AluAdd :
                       (f7 == rvIsaPkg::F7Alt) ? decodeCtrlPkg::AluSub : decodeCtrlPkg::AluNone;
            3'd1: op = decodeCtrlPkg::AluSll;
            3'd2: op = decodeCtrlPkg::AluSlt;
            3'd3: op = decodeCtrlPkg::AluSltu;
            3'd4: op = decodeCtrlPkg::AluXor;
            3'd6: op = decodeCtrlPkg::AluOr;
            3'd7: op = decodeCtrlPkg::AluAnd;
            default: op = (f7 == rvIsaPkg::F7Base) ? decodeCtrlPkg::AluSrl :
                          (f7 == rvIsaPkg::F7Alt) ? decodeCtrlPkg::AluSra : decodeCtrlPkg::AluNone;
        endcase
        return op;
    endfunction

    function automatic decodeCtrlPkg::ctrlWord expectCtrl(input rvIsaPkg::instrWord w);
        decodeCtrlPkg::ctrlWord c;
        rvIsaPkg::opcodeT       op;
        rvIsaPkg::funct3T       f3;
        rvIsaPkg::funct7T       f7;
        c  = '0;
        op = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        if (op inside {rvIsaPkg::OpAuipc, rvIsaPkg::OpLoad, rvIsaPkg::OpStore, rvIsaPkg::OpJalr,
                       rvIsaPkg::OpLoadFp, rvIsaPkg::OpStoreFp})
            c.aluOp = decodeCtrlPkg::AluAdd; // address or pc arithmetic
        if (op inside {rvIsaPkg::OpLui, rvIsaPkg::OpAuipc, rvIsaPkg::OpImm, rvIsaPkg::OpReg,
                       rvIsaPkg::OpLoad, rvIsaPkg::OpStore, rvIsaPkg::OpJalr,
                       rvIsaPkg::OpLoadFp, rvIsaPkg::OpStoreFp})
            c.aluSel = decodeCtrlPkg::SelInt;
        case (op)
            rvIsaPkg::OpLui, rvIsaPkg::OpAuipc: c.rawType = decodeCtrlPkg::TypeU;
            rvIsaPkg::OpImm, rvIsaPkg::OpLoad, rvIsaPkg::OpJalr, rvIsaPkg::OpLoadFp:
                c.rawType = decodeCtrlPkg::TypeI;
            rvIsaPkg::OpStore, rvIsaPkg::OpStoreFp: c.rawType = decodeCtrlPkg::TypeS;
            rvIsaPkg::OpBranch: c.rawType = decodeCtrlPkg::TypeB;
            rvIsaPkg::OpJal:    c.rawType = decodeCtrlPkg::TypeJ;
            default:            c.rawType = decodeCtrlPkg::TypeR;
        endcase
        c.regWe = !(op inside {rvIsaPkg::OpStore, rvIsaPkg::OpBranch, rvIsaPkg::OpStoreFp});
        c.memWe = op inside {rvIsaPkg::OpStore, rvIsaPkg::OpStoreFp};
        c.load  = op inside {rvIsaPkg::OpLoad, rvIsaPkg::OpLoadFp};
        c.jump  = op inside {rvIsaPkg::OpJal, rvIsaPkg::OpJalr};
        c.auipc = (op == rvIsaPkg::OpAuipc);
        case (op)
            rvIsaPkg::OpImm: c.aluOp = intAluOp(1'b0, f3, f7);
            rvIsaPkg::OpReg: c.aluOp = intAluOp(1'b1, f3, f7);
            rvIsaPkg::OpLoad, rvIsaPkg::OpStore: begin
                if (f3 == 3'd1 || (c.load && f3 == 3'd5))
                    c.dType = (f3 == 3'd1) ? decodeCtrlPkg::DtHalf : decodeCtrlPkg::DtHalfU;
                else if (f3 == 3'd2)
                    c.dType = decodeCtrlPkg::DtWord;
                else if (c.load && f3 == 3'd4)
                    c.dType = decodeCtrlPkg::DtByteU;
            end
            rvIsaPkg::OpBranch: begin
                if (f3 == 3'd1)
                    c.branchType = decodeCtrlPkg::BrNe;
                else if (f3 >= 3'd4)
                    c.branchType = decodeCtrlPkg::branchTypeE'(f3 - 3'd2); // blt..bgeu
            end
            rvIsaPkg::OpLoadFp: begin
                c.dType = decodeCtrlPkg::DtWord;
                c.fRd   = 1'b1;
            end
            rvIsaPkg::OpStoreFp: begin
                c.dType = decodeCtrlPkg::DtWord;
                c.fD2   = 1'b1;
            end
            rvIsaPkg::OpFp: begin
                c.aluSel = decodeCtrlPkg::SelFp;
                c.fD1    = 1'b1;
                c.fD2    = 1'b1;
                c.fRd    = 1'b1;
                case (f7)
                    rvIsaPkg::FAdd:    c.aluOp = decodeCtrlPkg::FaluAdd;
                    rvIsaPkg::FSub:    c.aluOp = decodeCtrlPkg::FaluSub;
                    rvIsaPkg::FMul:    c.aluOp = decodeCtrlPkg::FaluMul;
                    rvIsaPkg::FDiv:    c.aluOp = decodeCtrlPkg::FaluDiv;
                    rvIsaPkg::FSgnj:   c.aluOp = (f3 <= 3'd2) ? 5'd5 + f3 : 5'd0;
                    rvIsaPkg::FMinMax: c.aluOp = (f3 <= 3'd1) ? 5'd8 + f3 : 5'd0;
                    rvIsaPkg::FCmp: begin
                        c.fRd   = 1'b0; // compare result is an integer
                        c.aluOp = (f3 <= 3'd2) ? 5'd12 - f3 : 5'd0;
                    end
                    rvIsaPkg::FMvWX: begin
                        c.fD1 = 1'b0;
                        c.fD2 = 1'b0;
                    end
                    default: c.fRd = 1'b0;
                endcase
            end
            default: ;
        endcase
        // anything outside the twelve opcodes decodes to nothing
        if (!(op inside {rvIsaPkg::OpLui, rvIsaPkg::OpAuipc, rvIsaPkg::OpImm, rvIsaPkg::OpReg,
                         rvIsaPkg::OpLoad, rvIsaPkg::OpStore, rvIsaPkg::OpBranch,
                         rvIsaPkg::OpJal, rvIsaPkg::OpJalr, rvIsaPkg::OpLoadFp,
                         rvIsaPkg::OpStoreFp, rvIsaPkg::OpFp}))
            c = '0;
        return c;
    endfunction

    // ------------------------------------------------------------
    // stimulus and checks
    // ------------------------------------------------------------
    task automatic pickInstr(input int kind, output rvIsaPkg::instrWord w);
        int sel;
        w   = $random(seed); // random rd, rs1, rs2 and imm bits
        sel = {$random(seed)} % 9;
        if (kind == 3 || ({$random(seed)} % 8) == 0)
            return;
        case (kind)
            0: begin
                case (sel % 4)
                    0: w[6:0] = rvIsaPkg::OpLui;
                    1: w[6:0] = rvIsaPkg::OpAuipc;
                    2: w[6:0] = rvIsaPkg::OpImm;
                    default: w[6:0] = rvIsaPkg::OpReg;
                endcase
                case ({$random(seed)} % 3) // last choice keeps a random funct7
                    0: w[31:25] = rvIsaPkg::F7Base;
                    1: w[31:25] = rvIsaPkg::F7Alt;
                    default: ;
                endcase
            end
            1: begin
                case (sel % 5)
                    0: w[6:0] = rvIsaPkg::OpLoad;
                    1: w[6:0] = rvIsaPkg::OpStore;
                    2: w[6:0] = rvIsaPkg::OpBranch;
                    3: w[6:0] = rvIsaPkg::OpJal;
                    default: w[6:0] = rvIsaPkg::OpJalr;
                endcase
            end
            default: begin
                w[6:0] = (sel < 2) ? ((sel == 0) ? rvIsaPkg::OpLoadFp : rvIsaPkg::OpStoreFp)
                                   : rvIsaPkg::OpFp;
                case ({$random(seed)} % 9) // last choice keeps a random funct7
                    0: w[31:25] = rvIsaPkg::FAdd;
                    1: w[31:25] = rvIsaPkg::FSub;
                    2: w[31:25] = rvIsaPkg::FMul;
                    3: w[31:25] = rvIsaPkg::FDiv;
                    4: w[31:25] = rvIsaPkg::FSgnj;
                    5: w[31:25] = rvIsaPkg::FMinMax;
                    6: w[31:25] = rvIsaPkg::FCmp;
                    7: w[31:25] = rvIsaPkg::FMvWX;
                    default: ;
                endcase
            end
        endcase
    endtask

    task automatic checkCtrl(input string name, input decodeCtrlPkg::ctrlWord exp,
                             input decodeCtrlPkg::ctrlWord act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("FAIL %s ctrl expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkInstr(input string name, input rvIsaPkg::instrWord exp,
                              input rvIsaPkg::instrWord act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("FAIL %s instr expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("FAIL %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic runReset();
        int errorsBefore;
        errorsBefore = errorCount;
        arstN   = 1'b0;
        inValid = 1'b1; // must be ignored while in reset
        outReady = 1'b1;
        repeat (ResetCycles) begin
            @(negedge clk);
            #1;
            checkFlag("reset outValid", 1'b0, outValid);
            checkCtrl("reset", '0, outCtrl);
        end
        arstN   = 1'b1;
        inValid = 1'b0;
        repeat (2) begin
            @(negedge clk);
            #1;
            checkFlag("reset outValid", 1'b0, outValid);
            checkCtrl("reset", '0, outCtrl);
        end
        testCount++;
        $display("test %-14s errors %0d", "reset", errorCount - errorsBefore);
    endtask

    task automatic runTest(input string name, input int kind, input int count);
        int                 accepted;
        int                 errorsBefore;
        logic               pending;
        logic               full;
        rvIsaPkg::instrWord w;
        expItemT            e;
        accepted     = 0;
        errorsBefore = errorCount;
        pending      = 1'b0;
        while (accepted < count || expQ.size() != 0) begin
            @(negedge clk);
            if (!pending) begin
                inValid = 1'b0;
                if (accepted < count && ({$random(seed)} % 4) != 0) begin
                    pickInstr(kind, w);
                    inInstr = w;
                    inValid = 1'b1;
                    pending = 1'b1; // held until accepted
                end
            end
            outReady = ({$random(seed)} % 4) != 0;
            #1;
            full = (expQ.size() != 0); // one entry, so an unread item means a full stage
            checkFlag({name, " outValid"}, full, outValid);
            checkFlag({name, " inReady"}, !full || outReady, inReady);
            if (full && outReady) begin
                e = expQ.pop_front();
                checkInstr(name, e.instr, outInstr);
                checkCtrl(name, e.ctrl, outCtrl);
            end
            if (inValid && (!full || outReady)) begin
                expQ.push_back({inInstr, expectCtrl(inInstr)});
                accepted++;
                pending = 1'b0;
            end
        end
        testCount++;
        $display("test %-14s items %0d errors %0d", name, count, errorCount - errorsBefore);
    endtask

    // ------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        seed     = 32'h85fa8fa0;
        arstN    = 1'b0;
        inValid  = 1'b0;
        outReady = 1'b0;
        inInstr  = '0;
        runReset();
        runTest("intAlu", 0, 60);
        runTest("memBranchJump", 1, 60);
        runTest("floatOps", 2, 60);
        runTest("randomWords", 3, 40);
        // bound assertion failures
        errorCount += decoderTop_inst.decodeExecReg_inst.decoderTop_properties_inst.failCount;
        $display("tests %0d checks %0d errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial begin
        #((TotalItems * 20 + ResetCycles) * ClkPeriod);
        $display("timeout: the tests did not finish in the expected number of cycles");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== test/decoderTop_properties.sv ====
`timescale 1ns/1ps

module decoderTop_properties (
    input logic                   clk,
    input logic                   arstN,
    input logic                   outValid,
    input logic                   outReady,
    input rvIsaPkg::instrWord     outInstr,
    input decodeCtrlPkg::ctrlWord outCtrl
);

    int failCount = 0;

    // ------------------------------------------------------------
    // handshake and control word rules
    // ------------------------------------------------------------
    resetClearsValid: assert property (@(posedge clk) !arstN |-> !outValid)
        else begin
            $error("outValid high during reset");
            failCount++;
        end

    holdUnderStall: assert property (@(posedge clk) disable iff (!arstN)
        outValid && !outReady |=> outValid && $stable(outInstr) && $stable(outCtrl))
        else begin
            $error("outputs changed while stalled");
            failCount++;
        end

    // a store never writes back from the lsu
    noStoreLoad: assert property (@(posedge clk) disable iff (!arstN)
        !(outValid && outCtrl.memWe && outCtrl.load))
        else begin
            $error("memWe and load both set");
            failCount++;
        end

endmodule

bind decodeExecReg decoderTop_properties decoderTop_properties_inst (
    .clk      (clk),
    .arstN    (arstN),
    .outValid (outValid),
    .outReady (outReady),
    .outInstr (outInstr),
    .outCtrl  (outCtrl)
);

// ==== hw/decoderTop.sv ====
`timescale 1ns/1ps

module decoderTop (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   inValid,
    output logic                   inReady,
    input  rvIsaPkg::instrWord     inInstr,
    output logic                   outValid,
    input  logic                   outReady,
    output rvIsaPkg::instrWord     outInstr,
    output decodeCtrlPkg::ctrlWord outCtrl
);

    decodeCtrlPkg::ctrlWord intCtrl; // integer opcodes only
    decodeCtrlPkg::ctrlWord fpCtrl;  // flw, fsw, op-fp

    intDecoder intDecoder_inst (
        .instr (inInstr),
        .ctrl  (intCtrl)
    );

    fpDecoder fpDecoder_inst (
        .instr (inInstr),
        .ctrl  (fpCtrl)
    );

    decodeExecReg decodeExecReg_inst (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inInstr  (inInstr),
        .intCtrl  (intCtrl),
        .fpCtrl   (fpCtrl),
        .outValid (outValid),
        .outReady (outReady),
        .outInstr (outInstr),
        .outCtrl  (outCtrl)
    );

endmodule

// ==== hw/decodeExecReg.sv ====
`timescale 1ns/1ps

module decodeExecReg (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   inValid,
    output logic                   inReady,
    input  rvIsaPkg::instrWord     inInstr,
    input  decodeCtrlPkg::ctrlWord intCtrl,
    input  decodeCtrlPkg::ctrlWord fpCtrl,
    output logic                   outValid,
    input  logic                   outReady,
    output rvIsaPkg::instrWord     outInstr,
    output decodeCtrlPkg::ctrlWord outCtrl
);

    decodeCtrlPkg::ctrlWord mergedCtrl;
    logic                   accept;

    // decoders own disjoint opcodes so a plain or merges them
    assign mergedCtrl = decodeCtrlPkg::ctrlWord'(intCtrl | fpCtrl);

    assign inReady = !outValid || outReady; // empty or draining
    assign accept  = inValid && inReady;

    // ------------------------------------------------------------
    // single-entry decode/execute stage
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            outInstr <= '0;
            outCtrl  <= '0;
        end else begin
            if (inReady) begin
                outValid <= inValid; // drop valid once consumed
            end
            if (accept) begin
                outInstr <= inInstr;
                outCtrl  <= mergedCtrl;
            end
        end
    end

endmodule

// ==== hw/fpDecoder.sv ====
`timescale 1ns/1ps

module fpDecoder (
    input  rvIsaPkg::instrWord     instr,
    output decodeCtrlPkg::ctrlWord ctrl
);

    rvIsaPkg::opcodeT opcode;
    rvIsaPkg::funct3T funct3;
    rvIsaPkg::funct7T funct7;

    assign opcode = instr[rvIsaPkg::OpcodeWidth-1:0];
    assign funct3 = instr[rvIsaPkg::Funct3Pos +: rvIsaPkg::Funct3Width];
    assign funct7 = instr[rvIsaPkg::Funct7Pos +: rvIsaPkg::Funct7Width];

    always_comb begin
        ctrl = '0;
        case (opcode)
            rvIsaPkg::OpLoadFp: begin // base in int reg, data to float reg
                ctrl.aluOp   = decodeCtrlPkg::AluAdd;
                ctrl.aluSel  = decodeCtrlPkg::SelInt;
                ctrl.rawType = decodeCtrlPkg::TypeI;
                ctrl.dType   = decodeCtrlPkg::DtWord;
                ctrl.regWe   = 1'b1;
                ctrl.load    = 1'b1;
                ctrl.fRd     = 1'b1;
            end
            rvIsaPkg::OpStoreFp: begin
                ctrl.aluOp   = decodeCtrlPkg::AluAdd;
                ctrl.aluSel  = decodeCtrlPkg::SelInt;
                ctrl.rawType = decodeCtrlPkg::TypeS;
                ctrl.dType   = decodeCtrlPkg::DtWord;
                ctrl.memWe   = 1'b1;
                ctrl.fD2     = 1'b1; // store data from float rs2
            end
            rvIsaPkg::OpFp: begin
                ctrl.aluSel  = decodeCtrlPkg::SelFp;
                ctrl.rawType = decodeCtrlPkg::TypeR;
                ctrl.regWe   = 1'b1;
                ctrl.fD1     = 1'b1;
                ctrl.fD2     = 1'b1;
                case (funct7)
                    rvIsaPkg::FAdd: begin
                        ctrl.aluOp = decodeCtrlPkg::FaluAdd;
                        ctrl.fRd   = 1'b1;
                    end
                    rvIsaPkg::FSub: begin
                        ctrl.aluOp = decodeCtrlPkg::FaluSub;
                        ctrl.fRd   = 1'b1;
                    end
                    rvIsaPkg::FMul: begin
                        ctrl.aluOp = decodeCtrlPkg::FaluMul;
                        ctrl.fRd   = 1'b1;
                    end
                    rvIsaPkg::FDiv: begin
                        ctrl.aluOp = decodeCtrlPkg::FaluDiv;
                        ctrl.fRd   = 1'b1;
                    end
                    rvIsaPkg::FSgnj: begin
                        ctrl.fRd = 1'b1;
                        case (funct3)
                            rvIsaPkg::F3Sgnj:  ctrl.aluOp = decodeCtrlPkg::FaluSgnj;
                            rvIsaPkg::F3Sgnjn: ctrl.aluOp = decodeCtrlPkg::FaluSgnjn;
                            rvIsaPkg::F3Sgnjx: ctrl.aluOp = decodeCtrlPkg::FaluSgnjx;
                            default:           ctrl.aluOp = '0;
                        endcase
                    end
                    rvIsaPkg::FMinMax: begin
                        ctrl.fRd = 1'b1;
                        case (funct3)
                            rvIsaPkg::F3Min: ctrl.aluOp = decodeCtrlPkg::FaluMin;
                            rvIsaPkg::F3Max: ctrl.aluOp = decodeCtrlPkg::FaluMax;
                            default:         ctrl.aluOp = '0;
                        endcase
                    end
                    rvIsaPkg::FCmp: begin // result goes to int rd
                        case (funct3)
                            rvIsaPkg::F3Eq: ctrl.aluOp = decodeCtrlPkg::FaluEq;
                            rvIsaPkg::F3Lt: ctrl.aluOp = decodeCtrlPkg::FaluLt;
                            rvIsaPkg::F3Le: ctrl.aluOp = decodeCtrlPkg::FaluLe;
                            default:        ctrl.aluOp = '0;
                        endcase
                    end
                    rvIsaPkg::FMvWX: begin
                        // rs1 int plus x0, result lands in float rd
                        ctrl.aluOp = decodeCtrlPkg::FaluAdd;
                        ctrl.fRd   = 1'b1;
                        ctrl.fD1   = 1'b0;
                        ctrl.fD2   = 1'b0;
                    end
                    default: ctrl.aluOp = '0;
                endcase
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== hw/intDecoder.sv ====
`timescale 1ns/1ps

module intDecoder (
    input  rvIsaPkg::instrWord     instr,
    output decodeCtrlPkg::ctrlWord ctrl
);

    rvIsaPkg::opcodeT opcode;
    rvIsaPkg::funct3T funct3;
    rvIsaPkg::funct7T funct7;

    assign opcode = instr[rvIsaPkg::OpcodeWidth-1:0];
    assign funct3 = instr[rvIsaPkg::Funct3Pos +: rvIsaPkg::Funct3Width];
    assign funct7 = instr[rvIsaPkg::Funct7Pos +: rvIsaPkg::Funct7Width];

    // ------------------------------------------------------------
    // opcode groups, zero word for anything else
    // ------------------------------------------------------------
    always_comb begin
        ctrl = '0;
        case (opcode)
            rvIsaPkg::OpLui: begin
                ctrl.aluSel  = decodeCtrlPkg::SelInt;
                ctrl.rawType = decodeCtrlPkg::TypeU;
                ctrl.regWe   = 1'b1;
            end
            rvIsaPkg::OpAuipc: begin
                ctrl.aluOp   = decodeCtrlPkg::AluAdd; // pc + imm
                ctrl.aluSel  = decodeCtrlPkg::SelInt;
                ctrl.rawType = decodeCtrlPkg::TypeU;
                ctrl.regWe   = 1'b1;
                ctrl.auipc   = 1'b1;
            end
            rvIsaPkg::OpImm,
            rvIsaPkg::OpReg: begin
                ctrl.aluSel  = decodeCtrlPkg::SelInt;
                ctrl.rawType = (opcode == rvIsaPkg::OpImm) ? decodeCtrlPkg::TypeI
                                                           : decodeCtrlPkg::TypeR;
                ctrl.regWe   = 1'b1;
                case (funct3)
                    rvIsaPkg::F3AddSub: begin
                        if (opcode == rvIsaPkg::OpImm) begin
                            ctrl.aluOp = decodeCtrlPkg::AluAdd; // no subi
                        end else if (funct7 == rvIsaPkg::F7Base) begin
                            ctrl.aluOp = decodeCtrlPkg::AluAdd;
                        end else if (funct7 == rvIsaPkg::F7Alt) begin
                            ctrl.aluOp = decodeCtrlPkg::AluSub;
                        end
                    end
                    rvIsaPkg::F3Sll:  ctrl.aluOp = decodeCtrlPkg::AluSll;
                    rvIsaPkg::F3Slt:  ctrl.aluOp = decodeCtrlPkg::AluSlt;
                    rvIsaPkg::F3Sltu: ctrl.aluOp = decodeCtrlPkg::AluSltu;
                    rvIsaPkg::F3Xor:  ctrl.aluOp = decodeCtrlPkg::AluXor;
                    rvIsaPkg::F3Or:   ctrl.aluOp = decodeCtrlPkg::AluOr;
                    rvIsaPkg::F3And:  ctrl.aluOp = decodeCtrlPkg::AluAnd;
                    rvIsaPkg::F3Srl: begin
                        case (funct7) // logical or arithmetic
                            rvIsaPkg::F7Base: ctrl.aluOp = decodeCtrlPkg::AluSrl;
                            rvIsaPkg::F7Alt:  ctrl.aluOp = decodeCtrlPkg::AluSra;
                            default:          ctrl.aluOp = decodeCtrlPkg::AluNone;
                        endcase
                    end
                    default: ctrl.aluOp = decodeCtrlPkg::AluNone;
                endcase
            end
            rvIsaPkg::OpLoad: begin
                ctrl.aluOp   = decodeCtrlPkg::AluAdd; // address gen
                ctrl.aluSel  = decodeCtrlPkg::SelInt;
                ctrl.rawType = decodeCtrlPkg::TypeI;
                ctrl.regWe   = 1'b1;
                ctrl.load    = 1'b1;
                case (funct3)
                    rvIsaPkg::F3Half:  ctrl.dType = decodeCtrlPkg::DtHalf;
                    rvIsaPkg::F3Word:  ctrl.dType = decodeCtrlPkg::DtWord;
                    rvIsaPkg::F3ByteU: ctrl.dType = decodeCtrlPkg::DtByteU;
                    rvIsaPkg::F3HalfU: ctrl.dType = decodeCtrlPkg::DtHalfU;
                    default:           ctrl.dType = decodeCtrlPkg::DtByte;
                endcase
            end
            rvIsaPkg::OpStore: begin
                ctrl.aluOp   = decodeCtrlPkg::AluAdd;
                ctrl.aluSel  = decodeCtrlPkg::SelInt;
                ctrl.rawType = decodeCtrlPkg::TypeS;
                ctrl.memWe   = 1'b1;
                case (funct3)
                    rvIsaPkg::F3Half: ctrl.dType = decodeCtrlPkg::DtHalf;
                    rvIsaPkg::F3Word: ctrl.dType = decodeCtrlPkg::DtWord;
                    default:          ctrl.dType = decodeCtrlPkg::DtByte;
                endcase
            end
            rvIsaPkg::OpBranch: begin
                ctrl.rawType = decodeCtrlPkg::TypeB; // compare done in branch unit
                case (funct3)
                    rvIsaPkg::F3Bne:  ctrl.branchType = decodeCtrlPkg::BrNe;
                    rvIsaPkg::F3Blt:  ctrl.branchType = decodeCtrlPkg::BrLt;
                    rvIsaPkg::F3Bge:  ctrl.branchType = decodeCtrlPkg::BrGe;
                    rvIsaPkg::F3Bltu: ctrl.branchType = decodeCtrlPkg::BrLtu;
                    rvIsaPkg::F3Bgeu: ctrl.branchType = decodeCtrlPkg::BrGeu;
                    default:          ctrl.branchType = decodeCtrlPkg::BrEq;
                endcase
            end
            rvIsaPkg::OpJal: begin
                ctrl.rawType = decodeCtrlPkg::TypeJ;
                ctrl.regWe   = 1'b1; // link address
                ctrl.jump    = 1'b1;
            end
            rvIsaPkg::OpJalr: begin
                ctrl.aluOp   = decodeCtrlPkg::AluAdd; // rs1 + imm target
                ctrl.aluSel  = decodeCtrlPkg::SelInt;
                ctrl.rawType = decodeCtrlPkg::TypeI;
                ctrl.regWe   = 1'b1;
                ctrl.jump    = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== hw/decodeCtrlPkg.sv ====
package decodeCtrlPkg;

    typedef logic [4:0] aluOpT;

    // ------------------------------------------------------------
    // integer alu codes
    // ------------------------------------------------------------
    localparam aluOpT AluNone = 5'd0;
    localparam aluOpT AluSll  = 5'd1;
    localparam aluOpT AluSrl  = 5'd2;
    localparam aluOpT AluSra  = 5'd3;
    localparam aluOpT AluAdd  = 5'd4;
    localparam aluOpT AluSub  = 5'd5;
    localparam aluOpT AluAnd  = 5'd6;
    localparam aluOpT AluOr   = 5'd7;
    localparam aluOpT AluXor  = 5'd8;
    localparam aluOpT AluSltu = 5'd9;
    localparam aluOpT AluSlt  = 5'd10;
    localparam aluOpT AluMul    = 5'd11; // M extension, not decoded here
    localparam aluOpT AluMulh   = 5'd12;
    localparam aluOpT AluMulhsu = 5'd13;
    localparam aluOpT AluMulhu  = 5'd14;
    localparam aluOpT AluDiv    = 5'd15;
    localparam aluOpT AluDivu   = 5'd16;
    localparam aluOpT AluRem    = 5'd17;
    localparam aluOpT AluRemu   = 5'd18;

    // ------------------------------------------------------------
    // float alu codes, 4 is left free
    // ------------------------------------------------------------
    localparam aluOpT FaluAdd   = 5'd0;
    localparam aluOpT FaluSub   = 5'd1;
    localparam aluOpT FaluMul   = 5'd2;
    localparam aluOpT FaluDiv   = 5'd3;
    localparam aluOpT FaluSgnj  = 5'd5;
    localparam aluOpT FaluSgnjn = 5'd6;
    localparam aluOpT FaluSgnjx = 5'd7;
    localparam aluOpT FaluMin   = 5'd8;
    localparam aluOpT FaluMax   = 5'd9;
    localparam aluOpT FaluEq    = 5'd10;
    localparam aluOpT FaluLt    = 5'd11;
    localparam aluOpT FaluLe    = 5'd12;

    typedef enum logic [1:0] {SelNone, SelInt, SelFp} aluSelE;

    typedef enum logic [2:0] {TypeR, TypeI, TypeS, TypeB, TypeU, TypeJ} instrTypeE;

    typedef enum logic [2:0] {BrEq, BrNe, BrLt, BrGe, BrLtu, BrGeu} branchTypeE;

    typedef enum logic [2:0] {DtByte, DtHalf, DtWord, DtByteU, DtHalfU} dataTypeE;

    // decoded control for the execute stage
    typedef struct packed {
        aluOpT      aluOp;
        aluSelE     aluSel;     // which alu drives the result
        instrTypeE  rawType;    // immediate format
        branchTypeE branchType;
        dataTypeE   dType;      // lsu access size
        logic       memWe;
        logic       regWe;
        logic       jump;
        logic       load;       // writeback from lsu
        logic       auipc;
        logic       fRd;        // rd in float file
        logic       fD1;        // rs1 from float file
        logic       fD2;        // rs2 from float file
    } ctrlWord;

endpackage

// ==== hw/rvIsaPkg.sv ====
package rvIsaPkg;

    // ------------------------------------------------------------
    // field widths and positions
    // ------------------------------------------------------------
    localparam int XLen        = 32;
    localparam int OpcodeWidth = 7;
    localparam int Funct3Width = 3;
    localparam int Funct7Width = 7;
    localparam int Funct3Pos   = 12; // instr[14:12]
    localparam int Funct7Pos   = 25; // instr[31:25]

    typedef logic [XLen-1:0]        instrWord;
    typedef logic [OpcodeWidth-1:0] opcodeT;
    typedef logic [Funct3Width-1:0] funct3T;
    typedef logic [Funct7Width-1:0] funct7T;

    // ------------------------------------------------------------
    // major opcodes
    // ------------------------------------------------------------
    localparam opcodeT OpLui     = 7'b0110111;
    localparam opcodeT OpAuipc   = 7'b0010111;
    localparam opcodeT OpImm     = 7'b0010011; // addi and friends
    localparam opcodeT OpReg     = 7'b0110011; // register-register
    localparam opcodeT OpLoad    = 7'b0000011;
    localparam opcodeT OpStore   = 7'b0100011;
    localparam opcodeT OpBranch  = 7'b1100011;
    localparam opcodeT OpJal     = 7'b1101111;
    localparam opcodeT OpJalr    = 7'b1100111;
    localparam opcodeT OpLoadFp  = 7'b0000111; // flw
    localparam opcodeT OpStoreFp = 7'b0100111; // fsw
    localparam opcodeT OpFp      = 7'b1010011;

    // integer alu group
    localparam funct3T F3AddSub = 3'b000;
    localparam funct3T F3Sll    = 3'b001;
    localparam funct3T F3Slt    = 3'b010;
    localparam funct3T F3Sltu   = 3'b011;
    localparam funct3T F3Xor    = 3'b100;
    localparam funct3T F3Srl    = 3'b101; // srl and sra share this
    localparam funct3T F3Or     = 3'b110;
    localparam funct3T F3And    = 3'b111;

    // load/store width
    localparam funct3T F3Byte  = 3'b000;
    localparam funct3T F3Half  = 3'b001;
    localparam funct3T F3Word  = 3'b010;
    localparam funct3T F3ByteU = 3'b100; // loads only
    localparam funct3T F3HalfU = 3'b101; // loads only

    // branch conditions
    localparam funct3T F3Beq  = 3'b000;
    localparam funct3T F3Bne  = 3'b001;
    localparam funct3T F3Blt  = 3'b100;
    localparam funct3T F3Bge  = 3'b101;
    localparam funct3T F3Bltu = 3'b110;
    localparam funct3T F3Bgeu = 3'b111;

    // float sub-operations
    localparam funct3T F3Sgnj  = 3'b000;
    localparam funct3T F3Sgnjn = 3'b001;
    localparam funct3T F3Sgnjx = 3'b010;
    localparam funct3T F3Min   = 3'b000;
    localparam funct3T F3Max   = 3'b001;
    localparam funct3T F3Le    = 3'b000;
    localparam funct3T F3Lt    = 3'b001;
    localparam funct3T F3Eq    = 3'b010;

    // funct7 codes
    localparam funct7T F7Base  = 7'b0000000;
    localparam funct7T F7Alt   = 7'b0100000; // sub, sra, srai
    localparam funct7T FAdd    = 7'b0000000;
    localparam funct7T FSub    = 7'b0000100;
    localparam funct7T FMul    = 7'b0001000;
    localparam funct7T FDiv    = 7'b0001100;
    localparam funct7T FSgnj   = 7'b0010000;
    localparam funct7T FMinMax = 7'b0010100;
    localparam funct7T FCmp    = 7'b1010000;
    localparam funct7T FMvWX   = 7'b1111000; // int reg to float reg

endpackage
